// File: list.f
+incdir+.
priv_pkg.sv
priv_csr_rfile.sv
priv_trap_ctrl.sv
priv_csr_arbiter.sv
priv_pipe_ctrl.sv
priv_block.sv
priv_block_chk.sv
tb_priv_block.sv

// File: priv_block.sv
// ############################
// machine-mode privileged unit
// joins CSR file, trap controller,
// write arbiter and redirect logic
// ############################
`timescale 1ns/1ps

module priv_block
  import priv_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      fault_insn,
  input  logic      mal_insn,
  input  logic      illegal_insn,
  input  logic      fault_l,
  input  logic      mal_l,
  input  logic      fault_s,
  input  logic      mal_s,
  input  logic      breakpoint,
  input  logic      env_m,
  input  word_t     epc,
  input  word_t     badaddr,
  input  logic      ret,
  input  logic      swap,
  input  logic      set,
  input  logic      clr,
  input  csr_addr_t addr,
  input  word_t     wdata,
  input  logic      valid_write,
  input  logic      wb_enable,
  input  logic      instr,
  input  logic      timer_int,
  input  logic      ext_int,
  output word_t     priv_pc,
  output logic      insert_pc,
  output logic      intr,
  output word_t     rdata,
  output logic      invalid_csr
);

  word_t   mstatus;
  word_t   mie;
  word_t   mip;
  word_t   mtvec;
  word_t   mepc;
  logic    trap_req;
  word_t   trap_mepc;
  cause_t  trap_mcause;
  word_t   trap_mtval;
  word_t   trap_mstatus;
  logic    trap_taken;
  logic    mret_taken;
  cause_t  taken_cause;
  logic    wr_en;
  logic    wr_sel_insn;
  logic    wr_sel_trap;
  word_t   wr_data;
  wr_src_t wr_src;
  logic    instr_retired;

  // retired when writeback fires on a real instruction
  assign instr_retired = wb_enable & instr;

  priv_csr_rfile csr_rfile_i (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .addr         (addr),
    .wr_en        (wr_en),
    .wr_sel_insn  (wr_sel_insn),
    .wr_sel_trap  (wr_sel_trap),
    .wr_data      (wr_data),
    .trap_mepc    (trap_mepc),
    .trap_mcause  (trap_mcause),
    .trap_mtval   (trap_mtval),
    .trap_mstatus (trap_mstatus),
    .timer_int    (timer_int),
    .ext_int      (ext_int),
    .instr_retired(instr_retired),
    .rdata        (rdata),
    .invalid_csr  (invalid_csr),
    .mstatus      (mstatus),
    .mie          (mie),
    .mip          (mip),
    .mtvec        (mtvec),
    .mepc         (mepc)
  );

  priv_trap_ctrl trap_ctrl_i (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .fault_insn   (fault_insn),
    .mal_insn     (mal_insn),
    .illegal_insn (illegal_insn),
    .fault_l      (fault_l),
    .mal_l        (mal_l),
    .fault_s      (fault_s),
    .mal_s        (mal_s),
    .breakpoint   (breakpoint),
    .env_m        (env_m),
    .ret          (ret),
    .epc          (epc),
    .badaddr      (badaddr),
    .mstatus      (mstatus),
    .mie          (mie),
    .mip          (mip),
    .intr         (intr),
    .trap_req     (trap_req),
    .trap_mepc    (trap_mepc),
    .trap_mcause  (trap_mcause),
    .trap_mtval   (trap_mtval),
    .trap_mstatus (trap_mstatus),
    .trap_taken   (trap_taken),
    .mret_taken   (mret_taken),
    .taken_cause  (taken_cause)
  );

  priv_csr_arbiter csr_arbiter_i (
    .trap_req    (trap_req),
    .valid_write (valid_write),
    .swap        (swap),
    .set         (set),
    .clr         (clr),
    .wdata       (wdata),
    .rdata       (rdata),
    .invalid_csr (invalid_csr),
    .addr        (addr),
    .wr_en       (wr_en),
    .wr_sel_insn (wr_sel_insn),
    .wr_sel_trap (wr_sel_trap),
    .wr_data     (wr_data),
    .wr_src      (wr_src)
  );

  priv_pipe_ctrl pipe_ctrl_i (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .trap_taken  (trap_taken),
    .mret_taken  (mret_taken),
    .taken_cause (taken_cause),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .priv_pc     (priv_pc),
    .insert_pc   (insert_pc)
  );

endmodule

// File: priv_block_chk.sv
// ############################
// bound checks on the write
// arbiter and pipeline redirect
// ############################
`timescale 1ns/1ps

module priv_block_chk
  import priv_pkg::*;
(
  input logic    CLK,
  input logic    rst_n,
  input logic    insert_pc,
  input logic    trap_req,
  input wr_src_t wr_src
);

  // redirect is a single-cycle pulse
  a_insert_one_cycle: assert property (
    @(posedge CLK) disable iff (!rst_n) insert_pc |=> !insert_pc
  ) else $error("insert_pc stayed high for more than one cycle");

  // a trap always owns the write port
  a_trap_owns_port: assert property (
    @(posedge CLK) disable iff (!rst_n) trap_req |-> wr_src != src_insn
  ) else $error("csr instruction got the write port during a trap");

  // synchronous reset clears the redirect
  a_no_insert_in_reset: assert property (
    @(posedge CLK) !rst_n |=> !insert_pc
  ) else $error("insert_pc high while in reset");

endmodule

// attached at the top, where the arbiter and pipe_ctrl outputs meet
bind priv_block priv_block_chk chk_i (
  .CLK       (CLK),
  .rst_n     (rst_n),
  .insert_pc (insert_pc),
  .trap_req  (trap_req),
  .wr_src    (wr_src)
);

// File: priv_consts.svh
// ############################
// privileged unit constants
// machine CSR addresses, trap cause
// codes, mstatus bit positions and
// the hart id
// ############################
`ifndef PRIV_CONSTS_SVH
`define PRIV_CONSTS_SVH

// machine-mode CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MHARTID   12'hF14

// exception codes, mcause top bit clear
`define CAUSE_MAL_INSN    0
`define CAUSE_FAULT_INSN  1
`define CAUSE_ILLEGAL     2
`define CAUSE_BREAKPOINT  3
`define CAUSE_MAL_L       4
`define CAUSE_FAULT_L     5
`define CAUSE_MAL_S       6
`define CAUSE_FAULT_S     7
`define CAUSE_ENV_M       11

// interrupt codes, also the bit index in mie and mip
`define CAUSE_INT_TIMER   7
`define CAUSE_INT_EXT     11

// mstatus fields kept by this unit
`define MSTATUS_MIE   3
`define MSTATUS_MPIE  7

`define HART_ID  32'd0

`endif

// File: priv_csr_arbiter.sv
// ############################
// CSR write arbiter
// read-modify-write for csr insns,
// single write port with trap first
// ############################
`timescale 1ns/1ps
`include "priv_consts.svh"

module priv_csr_arbiter
  import priv_pkg::*;
(
  input  logic      trap_req,
  input  logic      valid_write,
  input  logic      swap,
  input  logic      set,
  input  logic      clr,
  input  word_t     wdata,
  input  word_t     rdata,
  input  logic      invalid_csr,
  input  csr_addr_t addr,
  output logic      wr_en,
  output logic      wr_sel_insn,
  output logic      wr_sel_trap,
  output word_t     wr_data,
  output wr_src_t   wr_src
);

  word_t rmw_data;
  logic  read_only;
  logic  insn_ok;

  // counters, pending bits and hart id cannot be written
  assign read_only = addr inside {`CSR_MIP, `CSR_MCYCLE, `CSR_MINSTRET, `CSR_MHARTID};

  always_comb begin
    if (swap) begin
      rmw_data = wdata;
    end else if (set) begin
      rmw_data = rdata | wdata;
    end else if (clr) begin
      rmw_data = rdata & ~wdata;
    end else begin
      rmw_data = rdata;
    end
  end

  // a trap flushes the instruction, so its write is dropped
  assign insn_ok = valid_write & (swap | set | clr) & ~invalid_csr & ~read_only & ~trap_req;

  assign wr_sel_trap = trap_req;
  assign wr_sel_insn = insn_ok;
  assign wr_en       = trap_req | insn_ok;
  assign wr_data     = rmw_data;

  always_comb begin
    if (trap_req) begin
      wr_src = src_trap;
    end else if (insn_ok) begin
      wr_src = src_insn;
    end else begin
      wr_src = src_none;
    end
  end

endmodule

// File: priv_csr_rfile.sv
// ############################
// CSR register file
// machine CSR storage, combinational
// read with unknown-address flag,
// cycle and retire counters, mip
// capture of the interrupt lines
// ############################
`timescale 1ns/1ps
`include "priv_consts.svh"

module priv_csr_rfile
  import priv_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  csr_addr_t addr,
  input  logic      wr_en,
  input  logic      wr_sel_insn,
  input  logic      wr_sel_trap,
  input  word_t     wr_data,
  input  word_t     trap_mepc,
  input  cause_t    trap_mcause,
  input  word_t     trap_mtval,
  input  word_t     trap_mstatus,
  input  logic      timer_int,
  input  logic      ext_int,
  input  logic      instr_retired,
  output word_t     rdata,
  output logic      invalid_csr,
  output word_t     mstatus,
  output word_t     mie,
  output word_t     mip,
  output word_t     mtvec,
  output word_t     mepc
);

  // only MIE and MPIE live in mstatus
  localparam word_t MSTATUS_MASK = (word_t'(1) << `MSTATUS_MIE) | (word_t'(1) << `MSTATUS_MPIE);
  // timer and external enables are the only mie bits
  localparam word_t MIE_MASK = (word_t'(1) << `CAUSE_INT_TIMER) | (word_t'(1) << `CAUSE_INT_EXT);

  word_t  mscratch;
  cause_t mcause;
  word_t  mtval;
  word_t  mcycle;
  word_t  minstret;
  word_t  mip_next;
  logic   insn_wr;
  logic   trap_wr;

  assign insn_wr = wr_en & wr_sel_insn;
  assign trap_wr = wr_en & wr_sel_trap;

  // interrupt levels placed at their mip bit
  always_comb begin
    mip_next = '0;
    mip_next[`CAUSE_INT_TIMER] = timer_int;
    mip_next[`CAUSE_INT_EXT]   = ext_int;
  end

  // trap controller presents the current value when idle,
  // so mstatus simply follows it unless software writes it
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mstatus <= '0;
    end else if (insn_wr && addr == `CSR_MSTATUS) begin
      mstatus <= wr_data & MSTATUS_MASK;
    end else begin
      mstatus <= trap_mstatus & MSTATUS_MASK;
    end
  end

  // software-only registers
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
    end else if (insn_wr) begin
      case (addr)
        `CSR_MIE:      mie      <= wr_data & MIE_MASK;
        `CSR_MTVEC:    mtvec    <= wr_data;
        `CSR_MSCRATCH: mscratch <= wr_data;
        default: ;
      endcase
    end
  end

  // trap state, a trap loads all three at once
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap_wr) begin
      mepc   <= trap_mepc;
      mcause <= trap_mcause;
      mtval  <= trap_mtval;
    end else if (insn_wr) begin
      case (addr)
        `CSR_MEPC:   mepc   <= wr_data;
        `CSR_MCAUSE: mcause <= wr_data;
        `CSR_MTVAL:  mtval  <= wr_data;
        default: ;
      endcase
    end
  end

  // counters and pending bits, read-only to software
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mcycle   <= '0;
      minstret <= '0;
      mip      <= '0;
    end else begin
      mcycle   <= mcycle + 32'd1;
      minstret <= minstret + word_t'(instr_retired);
      mip      <= mip_next;
    end
  end

  // read port, anything off the list is flagged
  always_comb begin
    rdata       = '0;
    invalid_csr = 1'b0;
    case (addr)
      `CSR_MSTATUS:  rdata = mstatus;
      `CSR_MIE:      rdata = mie;
      `CSR_MTVEC:    rdata = mtvec;
      `CSR_MSCRATCH: rdata = mscratch;
      `CSR_MEPC:     rdata = mepc;
      `CSR_MCAUSE:   rdata = mcause;
      `CSR_MTVAL:    rdata = mtval;
      `CSR_MIP:      rdata = mip;
      `CSR_MCYCLE:   rdata = mcycle;
      `CSR_MINSTRET: rdata = minstret;
      `CSR_MHARTID:  rdata = `HART_ID;
      default:       invalid_csr = 1'b1;
    endcase
  end

endmodule

// File: priv_pipe_ctrl.sv
// ############################
// pipeline redirect
// registers the one-cycle insert_pc
// pulse and the handler or return PC
// ############################
`timescale 1ns/1ps

module priv_pipe_ctrl
  import priv_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   trap_taken,
  input  logic   mret_taken,
  input  cause_t taken_cause,
  input  word_t  mtvec,
  input  word_t  mepc,
  output word_t  priv_pc,
  output logic   insert_pc
);

  word_t base;
  word_t vec_target;
  word_t trap_target;

  // low two bits of mtvec hold the mode
  assign base       = {mtvec[31:2], 2'b00};
  assign vec_target = base + {taken_cause[29:0], 2'b00};

  // vectored mode only applies to interrupts
  assign trap_target = (mtvec[0] && taken_cause[31]) ? vec_target : base;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      insert_pc <= 1'b0;
    end else begin
      insert_pc <= trap_taken | mret_taken;
    end
  end

  // mepc sampled here is the value before this edge's trap update
  always_ff @(posedge CLK) begin
    if (mret_taken) begin
      priv_pc <= mepc;
    end else if (trap_taken) begin
      priv_pc <= trap_target;
    end
  end

endmodule

// File: priv_pkg.sv
// ############################
// privileged unit types
// data word, CSR address, cause
// value and write-port owner
// ############################

package priv_pkg;

  // data word for CSR values, PCs and mtval
  typedef logic [31:0] word_t;

  // CSR address field of the csr instructions
  typedef logic [11:0] csr_addr_t;

  // mcause layout
  // bit 31 set for an interrupt, low bits carry the code
  typedef logic [31:0] cause_t;

  // owner of the single CSR write port in a cycle
  typedef enum logic [1:0] {
    // nobody writes
    src_none,
    // trap controller loads mepc, mcause, mtval and mstatus
    src_trap,
    // csr instruction writes the addressed register
    src_insn
  } wr_src_t;

endpackage

// File: priv_stim.txt
# exc ret op vw addr wdata epc badaddr wi irq | rdata inv intr ins pc mask, all hex
# exc lsb first: mal_i flt_i ill bkpt ecall mal_l mal_s flt_l flt_s; op 1 swap 2 set 4 clr
# wi 1 wb 2 instr; irq 1 timer 2 ext; mask 1 rdata 2 inv 4 intr 8 ins 10 pc
000 0 1 1 340 12345678 00000000 00000000 0 0 00000000 0 0 0 00000000 0f
000 0 2 1 340 0000f00f 00000000 00000000 0 0 12345678 0 0 0 00000000 0f
000 0 4 1 340 12000003 00000000 00000000 0 0 1234f67f 0 0 0 00000000 0f
000 0 0 0 340 00000000 00000000 00000000 0 0 0034f67c 0 0 0 00000000 0f
000 0 1 1 305 00000100 00000000 00000000 0 0 00000000 0 0 0 00000000 0f
000 0 2 1 305 00000200 00000000 00000000 0 0 00000100 0 0 0 00000000 0f
000 0 4 1 305 00000100 00000000 00000000 0 0 00000300 0 0 0 00000000 0f
000 0 1 1 7c0 ffffffff 00000000 00000000 0 0 00000000 1 0 0 00000000 0f
000 0 1 1 f14 ffffffff 00000000 00000000 0 0 00000000 0 0 0 00000000 0f
000 0 0 0 f14 00000000 00000000 00000000 0 0 00000000 0 0 0 00000000 0f
000 0 0 0 305 00000000 00000000 00000000 0 0 00000200 0 0 0 00000000 0f
001 0 0 0 343 00000000 00001000 00001001 0 0 00000000 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000000 0 0 1 00000200 1f
002 0 0 0 343 00000000 00001004 00001004 0 0 00001001 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000001 0 0 1 00000200 1f
004 0 0 0 343 00000000 00001008 deadbeef 0 0 00001004 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000002 0 0 1 00000200 1f
008 0 0 0 341 00000000 0000100c deadbeef 0 0 00001008 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000003 0 0 1 00000200 1f
010 0 0 0 343 00000000 00001010 deadbeef 0 0 00000000 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 0000000b 0 0 1 00000200 1f
020 0 0 0 341 00000000 00001014 00002002 0 0 00001010 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000004 0 0 1 00000200 1f
040 0 0 0 343 00000000 00001018 00003003 0 0 00002002 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000006 0 0 1 00000200 1f
080 0 0 0 343 00000000 0000101c 00004000 0 0 00003003 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000005 0 0 1 00000200 1f
100 0 0 0 343 00000000 00001020 00005000 0 0 00004000 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000007 0 0 1 00000200 1f
042 0 1 1 341 55555555 00001024 00006000 0 0 00001020 0 0 0 00000000 0f
000 0 0 0 341 00000000 00000000 00000000 0 0 00001024 0 0 1 00000200 1f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000001 0 0 0 00000000 0f
000 0 0 0 343 00000000 00000000 00000000 0 0 00006000 0 0 0 00000000 0f
000 0 1 1 305 00000401 00000000 00000000 0 0 00000200 0 0 0 00000000 0f
000 0 1 1 304 ffffffff 00000000 00000000 0 1 00000000 0 0 0 00000000 0f
000 0 0 0 304 00000000 00000000 00000000 0 1 00000880 0 0 0 00000000 0f
000 0 1 1 300 00000008 00000000 00000000 0 1 00000000 0 0 0 00000000 0f
000 0 0 0 300 00000000 00003000 00000000 0 1 00000008 0 1 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 80000007 0 0 1 0000041c 1f
000 0 0 0 300 00000000 00000000 00000000 0 0 00000080 0 0 0 00000000 0f
000 1 0 0 341 00000000 00000000 00000000 0 0 00003000 0 0 0 00000000 0f
000 0 0 0 300 00000000 00000000 00000000 0 0 00000088 0 0 1 00003000 1f
000 0 0 0 344 00000000 00000000 00000000 0 3 00000000 0 0 0 00000000 0f
000 0 0 0 344 00000000 00004000 00000000 0 0 00000880 0 1 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 8000000b 0 0 1 0000042c 1f
004 0 0 0 341 00000000 00004100 00000000 0 0 00004000 0 0 0 00000000 0f
000 0 0 0 342 00000000 00000000 00000000 0 0 00000002 0 0 1 00000400 1f
000 0 0 0 b02 00000000 00000000 00000000 3 0 00000000 0 0 0 00000000 0f
000 0 0 0 b02 00000000 00000000 00000000 1 0 00000001 0 0 0 00000000 0f
000 0 0 0 b02 00000000 00000000 00000000 3 0 00000001 0 0 0 00000000 0f
000 0 0 0 b02 00000000 00000000 00000000 2 0 00000002 0 0 0 00000000 0f
000 0 0 0 b02 00000000 00000000 00000000 3 0 00000002 0 0 0 00000000 0f
000 0 0 0 b02 00000000 00000000 00000000 0 0 00000003 0 0 0 00000000 0f
000 0 0 0 b00 00000000 00000000 00000000 0 0 00000035 0 0 0 00000000 0f

// File: priv_trap_ctrl.sv
// ############################
// trap controller
// ranks exceptions over interrupts,
// forms mcause, mepc, mtval and the
// next mstatus for a trap or mret
// ############################
`timescale 1ns/1ps
`include "priv_consts.svh"

module priv_trap_ctrl
  import priv_pkg::*;
(
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   fault_insn,
  input  logic   mal_insn,
  input  logic   illegal_insn,
  input  logic   fault_l,
  input  logic   mal_l,
  input  logic   fault_s,
  input  logic   mal_s,
  input  logic   breakpoint,
  input  logic   env_m,
  input  logic   ret,
  input  word_t  epc,
  input  word_t  badaddr,
  input  word_t  mstatus,
  input  word_t  mie,
  input  word_t  mip,
  output logic   intr,
  output logic   trap_req,
  output word_t  trap_mepc,
  output cause_t trap_mcause,
  output word_t  trap_mtval,
  output word_t  trap_mstatus,
  output logic   trap_taken,
  output logic   mret_taken,
  output cause_t taken_cause
);

  word_t  pending;
  cause_t exc_cause;
  cause_t int_cause;
  logic   exc_any;
  logic   exc_has_addr;
  logic   redirect_q;

  assign pending = mip & mie;
  assign intr    = mstatus[`MSTATUS_MIE] &
                   (pending[`CAUSE_INT_EXT] | pending[`CAUSE_INT_TIMER]);

  assign exc_any = mal_insn | fault_insn | illegal_insn | breakpoint | env_m |
                   mal_l | mal_s | fault_l | fault_s;

  // fixed exception priority where the first match wins
  always_comb begin
    exc_cause    = '0;
    exc_has_addr = 1'b0;
    if (mal_insn) begin
      exc_cause    = cause_t'(`CAUSE_MAL_INSN);
      exc_has_addr = 1'b1;
    end else if (fault_insn) begin
      exc_cause    = cause_t'(`CAUSE_FAULT_INSN);
      exc_has_addr = 1'b1;
    end else if (illegal_insn) begin
      exc_cause = cause_t'(`CAUSE_ILLEGAL);
    end else if (breakpoint) begin
      exc_cause = cause_t'(`CAUSE_BREAKPOINT);
    end else if (env_m) begin
      exc_cause = cause_t'(`CAUSE_ENV_M);
    end else if (mal_l) begin
      exc_cause    = cause_t'(`CAUSE_MAL_L);
      exc_has_addr = 1'b1;
    end else if (mal_s) begin
      exc_cause    = cause_t'(`CAUSE_MAL_S);
      exc_has_addr = 1'b1;
    end else if (fault_l) begin
      exc_cause    = cause_t'(`CAUSE_FAULT_L);
      exc_has_addr = 1'b1;
    end else if (fault_s) begin
      exc_cause    = cause_t'(`CAUSE_FAULT_S);
      exc_has_addr = 1'b1;
    end
  end

  // external ahead of timer
  assign int_cause = pending[`CAUSE_INT_EXT] ? {1'b1, 31'(`CAUSE_INT_EXT)}
                                             : {1'b1, 31'(`CAUSE_INT_TIMER)};

  // the cycle after a redirect carries only flushed work,
  // so no new event is accepted there and insert_pc stays a single pulse
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= trap_taken | mret_taken;
    end
  end

  assign trap_taken  = ~redirect_q & (exc_any | intr);
  assign mret_taken  = ~redirect_q & ret & ~(exc_any | intr);
  assign taken_cause = exc_any ? exc_cause : int_cause;

  assign trap_req    = trap_taken;
  assign trap_mepc   = epc;
  assign trap_mcause = taken_cause;
  // address only for misaligned and access faults
  assign trap_mtval  = exc_has_addr ? badaddr : '0;

  // next mstatus is the current one when nothing happens
  always_comb begin
    trap_mstatus = mstatus;
    if (trap_taken) begin
      trap_mstatus[`MSTATUS_MPIE] = mstatus[`MSTATUS_MIE];
      trap_mstatus[`MSTATUS_MIE]  = 1'b0;
    end else if (mret_taken) begin
      trap_mstatus[`MSTATUS_MIE]  = mstatus[`MSTATUS_MPIE];
      trap_mstatus[`MSTATUS_MPIE] = 1'b1;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# compile and run the priv_block testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_priv_block -f list.f -o tb_priv_block
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_priv_block > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_priv_block.sv
// ############################
// testbench for priv_block
// replays cycle vectors from the
// stim file, checks the outputs
// ############################
`timescale 1ns/1ps

module tb_priv_block
  import priv_pkg::*;
();

  // one cycle of inputs plus the expected outputs
  typedef struct packed {
    logic [8:0] exc;
    logic       ret;
    logic [2:0] op;
    logic       vw;
    csr_addr_t  addr;
    word_t      wdata;
    word_t      epc;
    word_t      badaddr;
    logic [1:0] wi;
    logic [1:0] irq;
    word_t      exp_rdata;
    logic       exp_inv;
    logic       exp_intr;
    logic       exp_ins;
    word_t      exp_pc;
    logic [4:0] mask;
  } vec_t;

  logic      CLK;
  logic      rst_n;
  logic      fault_insn;
  logic      mal_insn;
  logic      illegal_insn;
  logic      fault_l;
  logic      mal_l;
  logic      fault_s;
  logic      mal_s;
  logic      breakpoint;
  logic      env_m;
  word_t     epc;
  word_t     badaddr;
  logic      ret;
  logic      swap;
  logic      set;
  logic      clr;
  csr_addr_t addr;
  word_t     wdata;
  logic      valid_write;
  logic      wb_enable;
  logic      instr;
  logic      timer_int;
  logic      ext_int;
  word_t     priv_pc;
  logic      insert_pc;
  logic      intr;
  word_t     rdata;
  logic      invalid_csr;

  vec_t vecs[$];
  int   errors = 0;
  int   checks = 0;
  int   cur_vec = 0;
  int   cycles = 0;
  int   limit = 0;

  priv_block uut (.*);

  // 8 ns clock
  always #4 CLK = ~CLK;

  // watchdog, counts cycles out of reset
  always @(posedge CLK) begin
    if (rst_n) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
        $display("timeout: vectors did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
      end
    end
  end

  task automatic compare_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] vector %0d %s: got %h, expected %h", cur_vec, name, got, exp);
    end
  endtask

  // parse the stim file, lines starting with # are notes
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    vec_t        v;
    logic [31:0] f [0:15];
    fd = $fopen("priv_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open priv_stim.txt for reading");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
        if (n != 16) begin
          errors++;
          $display("malformed stim line, only %0d fields: %s", n, line);
        end else begin
          v.exc       = f[0][8:0];
          v.ret       = f[1][0];
          v.op        = f[2][2:0];
          v.vw        = f[3][0];
          v.addr      = f[4][11:0];
          v.wdata     = f[5];
          v.epc       = f[6];
          v.badaddr   = f[7];
          v.wi        = f[8][1:0];
          v.irq       = f[9][1:0];
          v.exp_rdata = f[10];
          v.exp_inv   = f[11][0];
          v.exp_intr  = f[12][0];
          v.exp_ins   = f[13][0];
          v.exp_pc    = f[14];
          v.mask      = f[15][4:0];
          vecs.push_back(v);
        end
      end
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      errors++;
      $display("no vectors found in priv_stim.txt");
    end
  endtask

  // strobe order follows the exc column, lsb first
  task automatic apply_vector(input vec_t v);
    mal_insn     = v.exc[0];
    fault_insn   = v.exc[1];
    illegal_insn = v.exc[2];
    breakpoint   = v.exc[3];
    env_m        = v.exc[4];
    mal_l        = v.exc[5];
    mal_s        = v.exc[6];
    fault_l      = v.exc[7];
    fault_s      = v.exc[8];
    ret          = v.ret;
    swap         = v.op[0];
    set          = v.op[1];
    clr          = v.op[2];
    valid_write  = v.vw;
    addr         = v.addr;
    wdata        = v.wdata;
    epc          = v.epc;
    badaddr      = v.badaddr;
    wb_enable    = v.wi[0];
    instr        = v.wi[1];
    timer_int    = v.irq[0];
    ext_int      = v.irq[1];
  endtask

  // mask picks which outputs this cycle pins down
  task automatic check_vector(input vec_t v);
    if (v.mask[0]) compare_value("rdata", rdata, v.exp_rdata);
    if (v.mask[1]) compare_value("invalid_csr", word_t'(invalid_csr), word_t'(v.exp_inv));
    if (v.mask[2]) compare_value("intr", word_t'(intr), word_t'(v.exp_intr));
    if (v.mask[3]) compare_value("insert_pc", word_t'(insert_pc), word_t'(v.exp_ins));
    if (v.mask[4]) compare_value("priv_pc", priv_pc, v.exp_pc);
  endtask

  initial begin
    CLK   = 1'b0;
    rst_n = 1'b0;
    apply_vector('0);
    load_vectors();
    limit = vecs.size() + 50;
    repeat (8) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    // drive 1 ns after the edge, sample 1 ns before the next one
    for (int i = 0; i < vecs.size(); i++) begin
      cur_vec = i;
      apply_vector(vecs[i]);
      #6;
      check_vector(vecs[i]);
      @(posedge CLK);
      #1;
    end
    $display("vectors: %0d  checks: %0d  errors: %0d", vecs.size(), checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
